//--- l2CachePkg.sv
// shared widths, ring and DDR encodings and cache geometry, imported by the cache RTL and its testbench
package l2CachePkg;

	// ring message fields
	localparam int addrWidth = 32;
	localparam int tileWidth = 128;
	localparam int seqWidth = 16;
	localparam int opmWidth = 16;

	// cache geometry, direct mapped
	localparam int tileOffsetBits = 4;
	localparam int tagWidth = addrWidth - tileOffsetBits;
	localparam int indexBits = 8;
	localparam int lineCount = 1 << indexBits;

	// low opm byte; OK codes keep a zero low nibble for the requester id
	typedef enum logic [7:0] {
		IDLE = 8'h00,
		LDX  = 8'h97,
		STX  = 8'hA7,
		OKLD = 8'h60,
		OKST = 8'h70
	} ringOpT;

	typedef enum logic [1:0] {REQ_NONE, REQ_LOAD, REQ_STORE} reqKindT;

	typedef enum logic [4:0] {
		OPM_READY   = 5'h00,
		OPM_RD_TILE = 5'h11,
		OPM_WR_TILE = 5'h12
	} ddrOpmT;

	typedef enum logic [1:0] {OK_READY = 2'd0, OK_OK = 2'd1, OK_HOLD = 2'd2} ddrOkT;

	// RAM window, top two bits clear and the next six not all zero
	function automatic logic ramWindow(input logic [addrWidth-1:0] addr);
		return (addr[31:30] == 2'b00) && (addr[29:24] != 6'h00);
	endfunction

	// fold the next index-sized slice of the tile address onto the low one
	function automatic logic [indexBits-1:0] indexHash(input logic [tagWidth-1:0] tag);
		return tag[indexBits-1:0] ^ tag[2*indexBits-1:indexBits];
	endfunction

endpackage

//--- ringRequestDecode.sv
// stage 1 of the tile cache: classifies ring messages, hashes the index and registers stage 2
`timescale 1ns/1ps

module ringRequestDecode
	import l2CachePkg::*;
(
	input  logic                 clock,
	input  logic [seqWidth-1:0]  ringSeqIn,
	input  logic [opmWidth-1:0]  ringOpmIn,
	input  logic [addrWidth-1:0] ringAddrIn,
	input  logic [tileWidth-1:0] ringDataIn,
	output logic [indexBits-1:0] readIndex,
	output logic [seqWidth-1:0]  reqSeq,
	output logic [opmWidth-1:0]  reqOpm,
	output logic [addrWidth-1:0] reqAddr,
	output logic [tileWidth-1:0] reqData,
	output logic [tagWidth-1:0]  reqTag,
	output logic [indexBits-1:0] reqIndex,
	output reqKindT              reqKind
);
	logic [tagWidth-1:0] inTag;
	logic inRam;
	reqKindT inKind;

	assign inTag = ringAddrIn[addrWidth-1:tileOffsetBits];
	assign inRam = ramWindow(ringAddrIn);
	// store read starts now so the line meets the request in stage 2
	assign readIndex = indexHash(inTag);

	always_comb
	begin
		inKind = REQ_NONE;
		if (inRam && (ringOpmIn[7:0] == LDX))
			inKind = REQ_LOAD;
		else if (inRam && (ringOpmIn[7:0] == STX))
			inKind = REQ_STORE;
	end

	always_ff @(posedge clock)
	begin
		reqSeq <= ringSeqIn;
		reqOpm <= ringOpmIn;
		reqAddr <= ringAddrIn;
		reqData <= ringDataIn;
		reqTag <= inTag;
		reqIndex <= readIndex;
		reqKind <= inKind;
	end

endmodule

//--- tileStore.sv
// line storage of the tile cache: tag and data arrays with dirty and valid flops, one read and one write port
`timescale 1ns/1ps

module tileStore
	import l2CachePkg::*;
(
	input  logic                 clock,
	input  logic                 reset,
	input  logic [indexBits-1:0] readIndex,
	output logic [tagWidth-1:0]  lineTag,
	output logic [tileWidth-1:0] lineData,
	output logic                 lineDirty,
	output logic                 lineValid,
	input  logic                 writeEnable,
	input  logic [indexBits-1:0] writeIndex,
	input  logic [tagWidth-1:0]  writeTag,
	input  logic [tileWidth-1:0] writeData,
	input  logic                 writeDirty,
	input  logic                 writeValid
);
	logic [tagWidth-1:0] tagArray [lineCount];
	logic [tileWidth-1:0] dataArray [lineCount];
	logic [lineCount-1:0] dirtyBits;
	logic [lineCount-1:0] validBits;

	// read returns the contents before a same-cycle write
	always_ff @(posedge clock)
	begin
		lineTag <= tagArray[readIndex];
		lineData <= dataArray[readIndex];
		lineDirty <= dirtyBits[readIndex];
		lineValid <= validBits[readIndex];
		if (writeEnable)
		begin
			tagArray[writeIndex] <= writeTag;
			dataArray[writeIndex] <= writeData;
			dirtyBits[writeIndex] <= writeDirty;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			validBits <= '0;
		else if (writeEnable)
			validBits[writeIndex] <= writeValid;
	end

endmodule

//--- lineControl.sv
// stage 2 of the tile cache: hit and miss decision, store update and write port arbitration
`timescale 1ns/1ps

module lineControl
	import l2CachePkg::*;
(
	input  logic                 clock,
	input  logic                 reset,
	input  reqKindT              reqKind,
	input  logic [tagWidth-1:0]  reqTag,
	input  logic [indexBits-1:0] reqIndex,
	input  logic [tileWidth-1:0] reqData,
	input  logic [tagWidth-1:0]  lineTag,
	input  logic [tileWidth-1:0] lineData,
	input  logic                 lineDirty,
	input  logic                 lineValid,
	input  logic                 fillWrite,
	input  logic [indexBits-1:0] fillIndex,
	input  logic [tagWidth-1:0]  fillTag,
	input  logic [tileWidth-1:0] fillData,
	input  logic                 engineBusy,
	output logic                 writeEnable,
	output logic [indexBits-1:0] writeIndex,
	output logic [tagWidth-1:0]  writeTag,
	output logic [tileWidth-1:0] writeData,
	output logic                 writeDirty,
	output logic                 writeValid,
	output logic                 missStart,
	output logic                 missLoad,
	output logic                 respond,
	output logic [tileWidth-1:0] respData
);
	logic [indexBits-1:0] lastWriteIndex;
	logic lastWriteValid;
	logic pendingLoad;
	logic isLoad;
	logic isStore;
	logic tagMatch;
	logic victimDirty;
	logic hazard;
	logic engineClash;
	logic hit;
	logic storeWrite;
	logic miss;

	assign isLoad = (reqKind == REQ_LOAD);
	assign isStore = (reqKind == REQ_STORE);
	assign tagMatch = lineValid && (lineTag == reqTag);
	assign victimDirty = lineValid && lineDirty;

	// read data is stale when the same line was written one cycle ago
	assign hazard = lastWriteValid && (reqIndex == lastWriteIndex);
	// line under write-back or fill belongs to the engine
	assign engineClash = engineBusy && (reqIndex == fillIndex);

	assign hit = isLoad && tagMatch && !hazard;
	// a clean or invalid line takes the store without a fetch
	assign storeWrite = isStore && (tagMatch || !victimDirty) && !hazard
		&& !engineClash && !fillWrite;
	assign miss = (isLoad && !tagMatch) || (isStore && !tagMatch && victimDirty);

	assign missStart = miss && !hazard && !engineBusy;
	assign missLoad = isLoad;
	assign respond = hit || storeWrite;
	assign respData = lineData;

	// fill has priority on the write port
	assign writeEnable = fillWrite || storeWrite;
	assign writeIndex = fillWrite ? fillIndex : reqIndex;
	assign writeTag = fillWrite ? fillTag : reqTag;
	assign writeData = fillWrite ? fillData : reqData;
	assign writeDirty = !fillWrite;
	assign writeValid = fillWrite ? pendingLoad : 1'b1;

	always_ff @(posedge clock)
	begin
		if (reset)
			lastWriteValid <= 1'b0;
		else
			lastWriteValid <= writeEnable;
	end

	always_ff @(posedge clock)
	begin
		lastWriteIndex <= writeIndex;
		// store-only write-back leaves the line invalid
		if (missStart)
			pendingLoad <= missLoad;
	end

endmodule

//--- tileFetchEngine.sv
// DDR engine that writes back a dirty victim and fetches the missed tile for the tile cache
`timescale 1ns/1ps

module tileFetchEngine
	import l2CachePkg::*;
(
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 missStart,
	input  logic                 missLoad,
	input  logic [indexBits-1:0] missIndex,
	input  logic [tagWidth-1:0]  missTag,
	input  logic [tagWidth-1:0]  victimTag,
	input  logic [tileWidth-1:0] victimData,
	input  logic                 victimDirty,
	output logic                 engineBusy,
	output logic                 fillWrite,
	output logic [indexBits-1:0] fillIndex,
	output logic [tagWidth-1:0]  fillTag,
	output logic [tileWidth-1:0] fillData,
	output logic [addrWidth-1:0] ddrAddr,
	output ddrOpmT               ddrOpm,
	output logic [tileWidth-1:0] ddrDataOut,
	input  logic [tileWidth-1:0] ddrDataIn,
	input  ddrOkT                ddrOk
);
	typedef enum logic [2:0] {idle, writeBack, writeWait, read, readWait, fill} engineStateT;

	engineStateT state;
	logic loadQ;
	logic [indexBits-1:0] indexQ;
	logic [tagWidth-1:0] tagQ;
	logic [tileWidth-1:0] tileQ;
	logic accept;

	assign accept = missStart && (state == idle);
	assign engineBusy = (state != idle);
	assign fillWrite = (state == fill);
	assign fillIndex = indexQ;
	assign fillTag = tagQ;
	assign fillData = tileQ;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= idle;
			ddrOpm <= OPM_READY;
		end
		else
		begin
			case (state)
				idle:
					if (missStart)
						state <= victimDirty ? writeBack : read;
				// commands go out only on a READY memory
				writeBack:
					if (ddrOk == OK_READY)
					begin
						ddrOpm <= OPM_WR_TILE;
						state <= writeWait;
					end
				writeWait:
					if (ddrOk == OK_OK)
					begin
						ddrOpm <= OPM_READY;
						state <= loadQ ? read : fill;
					end
				read:
					if (ddrOk == OK_READY)
					begin
						ddrOpm <= OPM_RD_TILE;
						state <= readWait;
					end
				readWait:
					if (ddrOk == OK_OK)
					begin
						ddrOpm <= OPM_READY;
						state <= fill;
					end
				default:
					state <= idle;
			endcase
		end
	end

	// miss latch and DDR address and data
	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			loadQ <= missLoad;
			indexQ <= missIndex;
			tagQ <= missTag;
			ddrAddr <= victimDirty ? {victimTag, {tileOffsetBits{1'b0}}}
				: {missTag, {tileOffsetBits{1'b0}}};
			ddrDataOut <= victimData;
		end
		else if ((state == writeWait) && (ddrOk == OK_OK))
			ddrAddr <= {tagQ, {tileOffsetBits{1'b0}}};
		if ((state == readWait) && (ddrOk == OK_OK))
			tileQ <= ddrDataIn;
	end

endmodule

//--- ringResponse.sv
// stages 3 and out of the tile cache: forms the OK answer or passes the message unchanged
`timescale 1ns/1ps

module ringResponse
	import l2CachePkg::*;
(
	input  logic                 clock,
	input  logic                 reset,
	input  logic [seqWidth-1:0]  reqSeq,
	input  logic [opmWidth-1:0]  reqOpm,
	input  logic [addrWidth-1:0] reqAddr,
	input  logic [tileWidth-1:0] reqData,
	input  reqKindT              reqKind,
	input  logic                 respond,
	input  logic [tileWidth-1:0] respData,
	output logic [seqWidth-1:0]  ringSeqOut,
	output logic [opmWidth-1:0]  ringOpmOut,
	output logic [addrWidth-1:0] ringAddrOut,
	output logic [tileWidth-1:0] ringDataOut
);
	logic [seqWidth-1:0] s3Seq;
	logic [opmWidth-1:0] s3Opm;
	logic [addrWidth-1:0] s3Addr;
	logic [tileWidth-1:0] s3Data;
	ringOpT okCode;
	logic [opmWidth-1:0] okOpm;

	assign okCode = (reqKind == REQ_LOAD) ? OKLD : OKST;
	// keep the high byte, requester id from bits 11:8 goes to the low nibble
	assign okOpm = {reqOpm[15:8], okCode[7:4], reqOpm[11:8]};

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			s3Opm <= '0;
			ringOpmOut <= '0;
		end
		else
		begin
			s3Opm <= respond ? okOpm : reqOpm;
			ringOpmOut <= s3Opm;
		end
	end

	always_ff @(posedge clock)
	begin
		s3Seq <= reqSeq;
		s3Addr <= reqAddr;
		s3Data <= (respond && (reqKind == REQ_LOAD)) ? respData : reqData;
		ringSeqOut <= s3Seq;
		ringAddrOut <= s3Addr;
		ringDataOut <= s3Data;
	end

endmodule

//--- l2TileCache.sv
// top level of the ring-bus L2 tile cache, connects the three pipeline stages and the DDR engine
`timescale 1ns/1ps

module l2TileCache
	import l2CachePkg::*;
(
	input  logic                 clock,
	input  logic                 reset,
	input  logic [seqWidth-1:0]  ringSeqIn,
	input  logic [opmWidth-1:0]  ringOpmIn,
	input  logic [addrWidth-1:0] ringAddrIn,
	input  logic [tileWidth-1:0] ringDataIn,
	output logic [seqWidth-1:0]  ringSeqOut,
	output logic [opmWidth-1:0]  ringOpmOut,
	output logic [addrWidth-1:0] ringAddrOut,
	output logic [tileWidth-1:0] ringDataOut,
	output logic [addrWidth-1:0] ddrAddr,
	output ddrOpmT               ddrOpm,
	output logic [tileWidth-1:0] ddrDataOut,
	input  logic [tileWidth-1:0] ddrDataIn,
	input  ddrOkT                ddrOk
);
	logic [indexBits-1:0] readIndex;
	logic [seqWidth-1:0] reqSeq;
	logic [opmWidth-1:0] reqOpm;
	logic [addrWidth-1:0] reqAddr;
	logic [tileWidth-1:0] reqData;
	logic [tagWidth-1:0] reqTag;
	logic [indexBits-1:0] reqIndex;
	reqKindT reqKind;

	logic [tagWidth-1:0] lineTag;
	logic [tileWidth-1:0] lineData;
	logic lineDirty;
	logic lineValid;

	logic writeEnable;
	logic [indexBits-1:0] writeIndex;
	logic [tagWidth-1:0] writeTag;
	logic [tileWidth-1:0] writeData;
	logic writeDirty;
	logic writeValid;

	logic fillWrite;
	logic [indexBits-1:0] fillIndex;
	logic [tagWidth-1:0] fillTag;
	logic [tileWidth-1:0] fillData;
	logic engineBusy;
	logic missStart;
	logic missLoad;
	logic respond;
	logic [tileWidth-1:0] respData;

	ringRequestDecode decode (
		.clock(clock), .ringSeqIn(ringSeqIn), .ringOpmIn(ringOpmIn),
		.ringAddrIn(ringAddrIn), .ringDataIn(ringDataIn), .readIndex(readIndex),
		.reqSeq(reqSeq), .reqOpm(reqOpm), .reqAddr(reqAddr), .reqData(reqData),
		.reqTag(reqTag), .reqIndex(reqIndex), .reqKind(reqKind)
	);

	tileStore store (
		.clock(clock), .reset(reset), .readIndex(readIndex),
		.lineTag(lineTag), .lineData(lineData), .lineDirty(lineDirty), .lineValid(lineValid),
		.writeEnable(writeEnable), .writeIndex(writeIndex), .writeTag(writeTag),
		.writeData(writeData), .writeDirty(writeDirty), .writeValid(writeValid)
	);

	lineControl control (
		.clock(clock), .reset(reset), .reqKind(reqKind), .reqTag(reqTag),
		.reqIndex(reqIndex), .reqData(reqData), .lineTag(lineTag), .lineData(lineData),
		.lineDirty(lineDirty), .lineValid(lineValid), .fillWrite(fillWrite),
		.fillIndex(fillIndex), .fillTag(fillTag), .fillData(fillData),
		.engineBusy(engineBusy), .writeEnable(writeEnable), .writeIndex(writeIndex),
		.writeTag(writeTag), .writeData(writeData), .writeDirty(writeDirty),
		.writeValid(writeValid), .missStart(missStart), .missLoad(missLoad),
		.respond(respond), .respData(respData)
	);

	// the victim is the line read for the missing request
	tileFetchEngine engine (
		.clock(clock), .reset(reset), .missStart(missStart), .missLoad(missLoad),
		.missIndex(reqIndex), .missTag(reqTag), .victimTag(lineTag),
		.victimData(lineData), .victimDirty(lineDirty && lineValid),
		.engineBusy(engineBusy), .fillWrite(fillWrite), .fillIndex(fillIndex),
		.fillTag(fillTag), .fillData(fillData), .ddrAddr(ddrAddr), .ddrOpm(ddrOpm),
		.ddrDataOut(ddrDataOut), .ddrDataIn(ddrDataIn), .ddrOk(ddrOk)
	);

	ringResponse response (
		.clock(clock), .reset(reset), .reqSeq(reqSeq), .reqOpm(reqOpm),
		.reqAddr(reqAddr), .reqData(reqData), .reqKind(reqKind), .respond(respond),
		.respData(respData), .ringSeqOut(ringSeqOut), .ringOpmOut(ringOpmOut),
		.ringAddrOut(ringAddrOut), .ringDataOut(ringDataOut)
	);

endmodule

//--- ddrTileModel.sv
// testbench DDR memory for the tile cache, answers after a random delay and logs every tile write
`timescale 1ns/1ps

module ddrTileModel
	import l2CachePkg::*;
(
	input  logic                 clock,
	input  logic                 reset,
	input  logic [addrWidth-1:0] ddrAddr,
	input  ddrOpmT               ddrOpm,
	input  logic [tileWidth-1:0] ddrDataOut,
	output logic [tileWidth-1:0] ddrDataIn,
	output ddrOkT                ddrOk
);
	integer seed = 32'hc85a_8d90;
	logic [tileWidth-1:0] mem [logic [addrWidth-1:0]];
	logic [addrWidth-1:0] logAddr [$];
	logic [tileWidth-1:0] logData [$];
	logic [1:0] waitCount;

	// content of a tile that was never written
	function automatic logic [tileWidth-1:0] backingTile(input logic [addrWidth-1:0] a);
		return {a, ~a, a ^ 32'h9e37_79b9, a[15:0], a[31:16]};
	endfunction

	always @(posedge clock)
	begin
		if (reset)
		begin
			ddrOk <= OK_READY;
			waitCount <= 2'd0;
			ddrDataIn <= '0;
		end
		else
		begin
			case (ddrOk)
				OK_READY:
					if (ddrOpm != OPM_READY)
					begin
						ddrOk <= OK_HOLD;
						waitCount <= 2'($random(seed) & 3);
					end
				OK_HOLD:
					if (waitCount == 2'd0)
					begin
						ddrOk <= OK_OK;
						if (ddrOpm == OPM_WR_TILE)
						begin
							mem[ddrAddr] = ddrDataOut;
							logAddr.push_back(ddrAddr);
							logData.push_back(ddrDataOut);
						end
						else
							ddrDataIn <= mem.exists(ddrAddr) ? mem[ddrAddr] : backingTile(ddrAddr);
					end
					else
						waitCount <= waitCount - 2'd1;
				default:
					// release only after the engine dropped its command
					if (ddrOpm == OPM_READY)
						ddrOk <= OK_READY;
			endcase
		end
	end

endmodule

//--- l2TileCache_props.sv
// DDR protocol assertions for the tile cache, bound to its top level
`timescale 1ns/1ps

module l2TileCache_props
	import l2CachePkg::*;
(
	input logic   clock,
	input logic   reset,
	input ddrOpmT ddrOpm,
	input ddrOkT  ddrOk
);
	readyAfterReset: assert property (@(posedge clock) reset |=> ddrOpm == OPM_READY)
		else $error("ddrOpm not READY after reset");

	// a new command only toward an idle memory
	issueOnReady: assert property (@(posedge clock) disable iff (reset)
		($past(ddrOpm) == OPM_READY && ddrOpm != OPM_READY) |-> $past(ddrOk) == OK_READY)
		else $error("ddrOpm issued while ddrOk not READY");

	heldOnHold: assert property (@(posedge clock) disable iff (reset)
		ddrOk == OK_HOLD |=> ddrOpm == $past(ddrOpm))
		else $error("ddrOpm changed under HOLD");

endmodule

bind l2TileCache l2TileCache_props props (
	.clock(clock), .reset(reset), .ddrOpm(ddrOpm), .ddrOk(ddrOk)
);

//--- tb_l2TileCache.sv
// replays the vector file into the L2 tile cache with retries and checks every answer
`timescale 1ns/1ps

module tb_l2TileCache;
	import l2CachePkg::*;

	localparam int period = 4;
	localparam int maxVectors = 64;

	logic clock;
	logic reset;
	logic [seqWidth-1:0] ringSeqIn;
	logic [opmWidth-1:0] ringOpmIn;
	logic [addrWidth-1:0] ringAddrIn;
	logic [tileWidth-1:0] ringDataIn;
	logic [seqWidth-1:0] ringSeqOut;
	logic [opmWidth-1:0] ringOpmOut;
	logic [addrWidth-1:0] ringAddrOut;
	logic [tileWidth-1:0] ringDataOut;
	logic [addrWidth-1:0] ddrAddr;
	ddrOpmT ddrOpm;
	logic [tileWidth-1:0] ddrDataOut;
	logic [tileWidth-1:0] ddrDataIn;
	ddrOkT ddrOk;

	// op, class, address, data
	logic [175:0] vecMem [maxVectors];
	int vecCount;
	int retryBound;
	logic [tileWidth-1:0] shadow [logic [addrWidth-1:0]];
	logic [seqWidth-1:0] nextSeq;

	l2TileCache DUT (.*);
	ddrTileModel ddrModel (.*);

	initial clock = 1'b0;
	always #(period / 2) clock = ~clock;

	task automatic reportFailure(input string what);
		$display("%s", what);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic checkField(input string name, input logic [tileWidth-1:0] got,
		input logic [tileWidth-1:0] exp);
		assert (got == exp)
		else reportFailure($sformatf("Mismatch %s got %h expected %h", name, got, exp));
	endtask

	function automatic logic [tileWidth-1:0] expectedBacking(input logic [addrWidth-1:0] a);
		return {a, ~a, a ^ 32'h9e37_79b9, a[15:0], a[31:16]};
	endfunction

	task automatic driveMsg(input logic [15:0] seq, input logic [15:0] opm,
		input logic [31:0] addr, input logic [127:0] data);
		@(posedge clock);
		ringSeqIn <= seq;
		ringOpmIn <= opm;
		ringAddrIn <= addr;
		ringDataIn <= data;
	endtask

	// one message, then the result 3 cycles later
	task automatic sendAndSample(input logic [15:0] seq, input logic [15:0] opm,
		input logic [31:0] addr, input logic [127:0] data, output logic [15:0] gotOpm,
		output logic [127:0] gotData);
		driveMsg(seq, opm, addr, data);
		driveMsg(16'h0, 16'h0, 32'h0, '0);
		repeat (3) @(negedge clock);
		checkField("ringSeqOut", 128'(ringSeqOut), 128'(seq));
		checkField("ringAddrOut", 128'(ringAddrOut), 128'(addr));
		gotOpm = ringOpmOut;
		gotData = ringDataOut;
	endtask

	// back-to-back pass-through messages keep order and latency
	task automatic runStream();
		logic [175:0] v [$];
		int n;
		for (int i = 0; i < vecCount; i++)
			if (vecMem[i][167:160] == 8'h00)
				v.push_back(vecMem[i]);
		n = v.size();
		fork
			begin
				for (int i = 0; i < n; i++)
					driveMsg(16'h8000 + 16'(i), {8'h35, v[i][175:168]}, v[i][159:128], v[i][127:0]);
				driveMsg(16'h0, 16'h0, 32'h0, '0);
			end
			begin
				@(posedge clock);
				repeat (4) @(negedge clock);
				for (int i = 0; i < n; i++)
				begin
					if (i > 0)
						@(negedge clock);
					checkField("ringSeqOut", 128'(ringSeqOut), 128'(16'h8000 + 16'(i)));
					checkField("ringOpmOut", 128'(ringOpmOut), 128'({8'h35, v[i][175:168]}));
					checkField("ringAddrOut", 128'(ringAddrOut), 128'(v[i][159:128]));
					checkField("ringDataOut", ringDataOut, v[i][127:0]);
				end
			end
		join
	endtask

	task automatic runRequest(input logic [175:0] v);
		logic [7:0] cls;
		logic [15:0] opm;
		logic [15:0] expOpm;
		logic [31:0] addr;
		logic [31:0] tile;
		logic [127:0] data;
		logic [15:0] gotOpm;
		logic [127:0] gotData;
		logic [127:0] expData;
		ringOpT okCode;
		bit answered;
		bit found;
		int tries;
		cls = v[167:160];
		opm = {8'h35, v[175:168]};
		addr = v[159:128];
		data = v[127:0];
		tile = {addr[31:4], 4'h0};
		okCode = (cls == 8'h02) ? OKST : OKLD;
		// high byte kept, OK code low byte with request bits 11:8 in its empty nibble
		expOpm = (opm & 16'hff00) | {8'h00, okCode} | {12'h000, opm[11:8]};
		nextSeq = nextSeq + 16'd1;
		answered = 1'b0;
		tries = 0;
		while (!answered)
		begin
			tries++;
			assert (tries <= retryBound)
			else reportFailure($sformatf("request to %h got no OK within %0d tries", addr, retryBound));
			sendAndSample(nextSeq, opm, addr, data, gotOpm, gotData);
			if (cls == 8'h00 || gotOpm == opm)
			begin
				checkField("ringOpmOut", 128'(gotOpm), 128'(opm));
				checkField("ringDataOut", gotData, data);
				answered = (cls == 8'h00);
				repeat (2) @(posedge clock);
			end
			else
			begin
				answered = 1'b1;
				checkField("ringOpmOut", 128'(gotOpm), 128'(expOpm));
				if (cls == 8'h02)
				begin
					checkField("ringDataOut", gotData, data);
					shadow[tile] = data;
				end
				else
				begin
					expData = shadow.exists(tile) ? shadow[tile] : expectedBacking(tile);
					checkField("ringDataOut", gotData, expData);
				end
			end
		end
		// the dirty victim must have reached DDR
		if (cls == 8'h03)
		begin
			found = 1'b0;
			foreach (ddrModel.logAddr[k])
				if (ddrModel.logAddr[k] == data[31:0] && ddrModel.logData[k] == shadow[data[31:0]])
					found = 1'b1;
			assert (found)
			else reportFailure($sformatf("no write-back of the dirty tile at %h in DDR", data[31:0]));
		end
	endtask

	initial
	begin
		reset = 1'b1;
		ringSeqIn = '0;
		ringOpmIn = '0;
		ringAddrIn = '0;
		ringDataIn = '0;
		nextSeq = 16'h0;
		for (int k = 0; k < maxVectors; k++)
			vecMem[k] = '1;
		$readmemh("l2_vectors.txt", vecMem);
		vecCount = 0;
		while (vecCount < maxVectors && vecMem[vecCount][175:168] != 8'hff)
			vecCount++;
		retryBound = 8 * vecCount;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		repeat (2) @(posedge clock);
		runStream();
		for (int i = 0; i < vecCount; i++)
			runRequest(vecMem[i]);
		repeat (4) @(posedge clock);
		$display("Verification passed");
		$finish;
	end

	// watchdog sized from the vector count and the retry bound
	initial
	begin
		#1;
		#((vecCount * retryBound * 8 + 200) * period);
		reportFailure("simulation timed out before all vectors completed");
	end

endmodule

//--- l2_vectors.txt
// op(8) class(8) addr(32) data(128); class 0 pass, 1 load, 2 store, 3 load with write-back
// for class 3 the low data word is the address of the dirty victim tile
00_00_00000000_00000000_00000000_00000000_00000000
97_00_80001000_01234567_89abcdef_fedcba98_76543210
a7_00_00002000_11111111_22222222_33333333_44444444
97_01_01000100_00000000_00000000_00000000_00000000
a7_02_01000100_a5a5a5a5_11112222_33334444_55556666
97_01_01000100_00000000_00000000_00000000_00000000
97_03_02000100_00000000_00000000_00000000_01000100
97_01_01000100_00000000_00000000_00000000_00000000
a7_02_03000200_c3c3c3c3_77778888_9999aaaa_bbbbcccc
a7_02_01001110_0f0f0f0f_f0f0f0f0_12345678_9abcdef0
97_01_01001110_00000000_00000000_00000000_00000000
97_01_03000200_00000000_00000000_00000000_00000000
97_03_02000100_00000000_00000000_00000000_01001110

//--- vlog.f
l2CachePkg.sv
ringRequestDecode.sv
tileStore.sv
lineControl.sv
tileFetchEngine.sv
ringResponse.sv
l2TileCache.sv
ddrTileModel.sv
l2TileCache_props.sv
tb_l2TileCache.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_l2TileCache
FLIST ?= vlog.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: all run lint clean

all: run

run:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Verification passed"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR)
